/* verilog/nocPkg.sv */
`default_nettype none

package nocPkg;

  // ====================================================================
  // Router geometry
  // ====================================================================

  localparam int numPorts = 5;

  // Input indices. They also fix the priority order out of idle.
  localparam int portLocal = 0;
  localparam int portNorth = 1;
  localparam int portEast  = 2;
  localparam int portWest  = 3;
  localparam int portSouth = 4;

  // ====================================================================
  // Flit fields
  // ====================================================================

  localparam int flitIdWidth = 3;
  localparam int lengthWidth = 12; // Hold limit carried by header flits.
  localparam int dataWidth   = 32;

  localparam logic [flitIdWidth-1:0] flitHeader = 3'd1;

  // ====================================================================
  // Grant encoding
  // ====================================================================

  // One-hot state. Bit 0 is idle, bit i+1 means input i owns the link.
  localparam int grantWidth = numPorts + 1;

  localparam logic [grantWidth-1:0] grantIdle = 6'b000001;

endpackage

`default_nettype wire

/* verilog/grantFsm.sv */
`timescale 1ns/1ps
`default_nettype none

module grantFsm
(
  input  wire logic                       clk,
  input  wire logic                       rst,
  input  wire logic [nocPkg::numPorts-1:0] req,
  input  wire logic [nocPkg::numPorts-1:0] timesUp,
  output logic      [nocPkg::numPorts-1:0] grant,
  output logic      [nocPkg::numPorts-1:0] runTimer
);

  import nocPkg::*;

  logic [grantWidth-1:0] state;
  logic [grantWidth-1:0] nextState;

  // Scans count inputs starting at first, wrapping round, and returns the
  // one-hot state of the first requester found, or idle.
  function automatic logic [grantWidth-1:0] firstReq
  (
    input logic [numPorts-1:0] r,
    input int                  first,
    input int                  count
  );
    logic [grantWidth-1:0] pick;
    int                    idx;
    pick = grantIdle;
    // Walk backwards so that the earliest candidate is the one that sticks.
    for (int k = count - 1; k >= 0; k--)
    begin
      idx = (first + k) % numPorts;
      if (r[idx])
        pick = grantWidth'(1) << (idx + 1);
    end
    return pick;
  endfunction

  // ====================================================================
  // State register
  // ====================================================================

  always_ff @(posedge clk)
  begin
    if (rst)
      state <= grantIdle;
    else
      state <= nextState;
  end

  assign grant = state[grantWidth-1:1]; // Idle bit dropped.

  // ====================================================================
  // Next state and timer enables
  // ====================================================================

  always_comb
  begin
    nextState = firstReq(req, portLocal, numPorts); // From idle L wins over S.
    runTimer  = '0;
    for (int i = 0; i < numPorts; i++)
    begin
      if (state[i+1])
      begin
        if (req[i] && !timesUp[i])
        begin
          runTimer[i] = 1'b1;
          nextState   = state;
        end
        else
          // The owner itself is not a candidate on the way out.
          nextState = firstReq(req, i + 1, numPorts - 1);
      end
    end
  end

  // ====================================================================
  // Assertions
  // ====================================================================

  stateOneHot: assert property (@(posedge clk) disable iff (rst) $onehot(state))
    else $error("grantFsm: state is not one-hot");

  // Time-up with a waiting input must hand the link over on the next edge.
  holdEndsAtTimeUp: assert property (@(posedge clk) disable iff (rst)
    (|(grant & timesUp)) && (|(req & ~grant)) |=> (grant & $past(grant)) == '0)
    else $error("grantFsm: grant held past time-up");

endmodule

`default_nettype wire

/* verilog/grantTimer.sv */
`timescale 1ns/1ps
`default_nettype none

module grantTimer
(
  input  wire logic                          clk,
  input  wire logic                          rst,
  input  wire logic [nocPkg::flitIdWidth-1:0] flitId,
  input  wire logic [nocPkg::lengthWidth-1:0] length,
  input  wire logic                          runTimer,
  output logic                               timesUp
);

  import nocPkg::*;

  logic [lengthWidth-1:0] limit;
  logic [lengthWidth-1:0] count;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      limit <= '0;
      count <= '0;
    end
    else
    begin
      // Any header on this input refreshes the limit, granted or not.
      if (flitId == flitHeader)
        limit <= length;
      if (runTimer)
        count <= count + 1'b1;
      else
        count <= '0; // A lost grant starts the next hold from zero.
    end
  end

  assign timesUp = (count == limit);

  // The FSM must stop running the timer once the count reaches the limit,
  // otherwise the count would step past it.
  countAtLimit: assert property (@(posedge clk) disable iff (rst)
    count == limit |-> !runTimer)
    else $error("grantTimer: count advanced past the limit");

endmodule

`default_nettype wire

/* verilog/flitMux.sv */
`timescale 1ns/1ps
`default_nettype none

module flitMux
(
  input  wire logic [nocPkg::numPorts-1:0]                       grant,
  input  wire logic [nocPkg::numPorts-1:0]                       req,
  input  wire logic [nocPkg::numPorts-1:0][nocPkg::dataWidth-1:0] flitData,
  output logic                                                    outValid,
  output logic      [nocPkg::dataWidth-1:0]                       outData
);

  import nocPkg::*;

  // ====================================================================
  // AND-OR selection
  // ====================================================================

  // With a one-hot grant at most one term is non-zero, so no priority
  // logic is needed here.
  always_comb
  begin
    outData  = '0;
    outValid = 1'b0;
    for (int i = 0; i < numPorts; i++)
    begin
      outData  = outData | (flitData[i] & {dataWidth{grant[i]}});
      outValid = outValid | (grant[i] & req[i]); // Owner still sending.
    end
  end

  // A second grant bit would OR two flits together on the link.
  always_comb
  begin
    grantOneHot: assert ($onehot0(grant))
      else $error("flitMux: more than one input granted");
  end

endmodule

`default_nettype wire

/* verilog/routerOutputPort.sv */
`timescale 1ns/1ps
`default_nettype none

module routerOutputPort
(
  input  wire logic                                                 clk,
  input  wire logic                                                 rst,
  input  wire logic [nocPkg::numPorts-1:0]                          req,
  input  wire logic [nocPkg::numPorts-1:0][nocPkg::flitIdWidth-1:0] flitId,
  input  wire logic [nocPkg::numPorts-1:0][nocPkg::lengthWidth-1:0] length,
  input  wire logic [nocPkg::numPorts-1:0][nocPkg::dataWidth-1:0]   flitData,
  output logic      [nocPkg::numPorts-1:0]                          grant,
  output logic                                                      outValid,
  output logic      [nocPkg::dataWidth-1:0]                         outData
);

  import nocPkg::*;

  logic [numPorts-1:0] runTimer;
  logic [numPorts-1:0] timesUp;

  // ====================================================================
  // Arbitration
  // ====================================================================

  grantFsm i_grantFsm
  (
    .clk      (clk),
    .rst      (rst),
    .req      (req),
    .timesUp  (timesUp),
    .grant    (grant),
    .runTimer (runTimer)
  );

  // One hold timer per input.
  grantTimer timerLocal
  (
    .clk      (clk),
    .rst      (rst),
    .flitId   (flitId[portLocal]),
    .length   (length[portLocal]),
    .runTimer (runTimer[portLocal]),
    .timesUp  (timesUp[portLocal])
  );

  grantTimer timerNorth
  (
    .clk      (clk),
    .rst      (rst),
    .flitId   (flitId[portNorth]),
    .length   (length[portNorth]),
    .runTimer (runTimer[portNorth]),
    .timesUp  (timesUp[portNorth])
  );

  grantTimer timerEast
  (
    .clk      (clk),
    .rst      (rst),
    .flitId   (flitId[portEast]),
    .length   (length[portEast]),
    .runTimer (runTimer[portEast]),
    .timesUp  (timesUp[portEast])
  );

  grantTimer timerWest
  (
    .clk      (clk),
    .rst      (rst),
    .flitId   (flitId[portWest]),
    .length   (length[portWest]),
    .runTimer (runTimer[portWest]),
    .timesUp  (timesUp[portWest])
  );

  grantTimer timerSouth
  (
    .clk      (clk),
    .rst      (rst),
    .flitId   (flitId[portSouth]),
    .length   (length[portSouth]),
    .runTimer (runTimer[portSouth]),
    .timesUp  (timesUp[portSouth])
  );

  // ====================================================================
  // Data path
  // ====================================================================

  flitMux i_flitMux
  (
    .grant    (grant),
    .req      (req),
    .flitData (flitData),
    .outValid (outValid),
    .outData  (outData)
  );

endmodule

`default_nettype wire

/* sim/routerOutputPortTb.sv */
`timescale 1ns/1ps
`default_nettype none

module routerOutputPortTb;

  import nocPkg::*;

  localparam logic [flitIdWidth-1:0] flitBody = 3'd2;

  // Cycle budget of each test. The run is stopped at one and a half times their sum.
  localparam int cyclesReset    = 10;
  localparam int cyclesPriority = 16;
  localparam int cyclesRotation = 56;
  localparam int cyclesHeader   = 45;
  localparam int cyclesData     = 42;
  localparam int cyclesRandom   = 304;
  localparam int timeoutCycles  = (cyclesReset + cyclesPriority + cyclesRotation
                                   + cyclesHeader + cyclesData + cyclesRandom) * 3 / 2;

  logic                                 clk;
  logic                                 rst;
  logic [numPorts-1:0]                  req;
  logic [numPorts-1:0][flitIdWidth-1:0] flitId;
  logic [numPorts-1:0][lengthWidth-1:0] length;
  logic [numPorts-1:0][dataWidth-1:0]   flitData;
  logic [numPorts-1:0]                  grant;
  logic                                 outValid;
  logic [dataWidth-1:0]                 outData;

  // Values that go to the DUT on the next rising edge.
  logic                                 nextRst;
  logic [numPorts-1:0]                  nextReq;
  logic [numPorts-1:0][flitIdWidth-1:0] nextId;
  logic [numPorts-1:0][lengthWidth-1:0] nextLen;
  logic [numPorts-1:0][dataWidth-1:0]   nextData;

  int                     modelOwner; // Input that owns the link, -1 when idle.
  logic [lengthWidth-1:0] modelLimit [numPorts];
  logic [lengthWidth-1:0] modelCount [numPorts];

  logic [15:0] lfsr;
  int          cycles = 0;
  int          passCount;
  int          errorCount;
  int          testNum;
  int          testStartErrors;

  routerOutputPort i_routerOutputPort
  (
    .clk      (clk),
    .rst      (rst),
    .req      (req),
    .flitId   (flitId),
    .length   (length),
    .flitData (flitData),
    .grant    (grant),
    .outValid (outValid),
    .outData  (outData)
  );

  always #50 clk = ~clk;

  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if (cycles >= timeoutCycles)
    begin
      $display("timeout: run stopped after %0d cycles", cycles);
      $display(">>> FAIL");
      $finish;
    end
  end

  // ====================================================================
  // Random numbers
  // ====================================================================

  // Taps 16, 14, 13 and 11.
  function automatic logic [15:0] lfsrStep(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic randBits(input int n, output logic [31:0] value);
    value = '0;
    for (int k = 0; k < n; k++)
    begin
      lfsr  = lfsrStep(lfsr);
      value = {value[30:0], lfsr[0]};
    end
  endtask

  task automatic randomData();
    logic [31:0] bits;
    for (int i = 0; i < numPorts; i++)
    begin
      randBits(dataWidth, bits);
      nextData[i] = bits;
    end
  endtask

  // Requests tend to stay up once raised.
  task automatic randomInputs();
    logic [31:0] bits;
    for (int i = 0; i < numPorts; i++)
    begin
      if (nextReq[i])
      begin
        randBits(3, bits);
        nextReq[i] = (bits[2:0] != 3'd0);
      end
      else
      begin
        randBits(2, bits);
        nextReq[i] = (bits[1:0] == 2'd0);
      end
      randBits(2, bits);
      nextId[i] = (bits[1:0] == 2'd0) ? flitHeader : flitBody;
      randBits(3, bits);
      nextLen[i] = lengthWidth'(bits[2:0]);
    end
    randomData();
  endtask

  // ====================================================================
  // Reference model
  // ====================================================================

  task automatic modelStep();
    logic [numPorts-1:0] run;
    int                  nextOwner;
    int                  cand;
    run       = '0;
    nextOwner = -1;
    if (rst)
    begin
      modelOwner = -1;
      for (int i = 0; i < numPorts; i++)
      begin
        modelLimit[i] = '0;
        modelCount[i] = '0;
      end
    end
    else
    begin
      if (modelOwner < 0)
      begin
        for (int i = numPorts - 1; i >= 0; i--) // Lowest index wins from idle.
          if (req[i])
            nextOwner = i;
      end
      else if (req[modelOwner] && modelCount[modelOwner] != modelLimit[modelOwner])
      begin
        nextOwner       = modelOwner;
        run[modelOwner] = 1'b1;
      end
      else
      begin
        for (int k = 1; k < numPorts; k++)
        begin
          cand = (modelOwner + k) % numPorts;
          if (nextOwner < 0 && req[cand])
            nextOwner = cand;
        end
      end
      for (int i = 0; i < numPorts; i++)
      begin
        if (flitId[i] == flitHeader)
          modelLimit[i] = length[i];
        if (run[i])
          modelCount[i] = modelCount[i] + 1'b1;
        else
          modelCount[i] = '0;
      end
      modelOwner = nextOwner;
    end
  endtask

  // ====================================================================
  // Checks
  // ====================================================================

  task automatic checkValue(input string name, input logic [31:0] actual,
                            input logic [31:0] expected);
    assert (actual === expected)
      passCount++;
    else
    begin
      errorCount++;
      $display("error: %s = 0x%h, expected 0x%h at cycle %0d", name, actual, expected, cycles);
    end
  endtask

  task automatic checkTrue(input logic cond, input string what);
    assert (cond)
      passCount++;
    else
    begin
      errorCount++;
      $display("check failed: %s at cycle %0d", what, cycles);
    end
  endtask

  task automatic checkOutputs();
    logic [numPorts-1:0]  expGrant;
    logic                 expValid;
    logic [dataWidth-1:0] expData;
    expGrant = '0;
    expValid = 1'b0;
    expData  = '0;
    if (modelOwner >= 0)
    begin
      expGrant = numPorts'(1) << modelOwner;
      expValid = req[modelOwner];
      expData  = flitData[modelOwner];
    end
    checkValue("grant", 32'(grant), 32'(expGrant));
    checkValue("outValid", 32'(outValid), 32'(expValid));
    checkValue("outData", outData, expData);
  endtask

  function automatic int grantIndex(input logic [numPorts-1:0] g);
    int idx;
    idx = -1;
    for (int i = 0; i < numPorts; i++)
      if (g[i])
        idx = i;
    return idx;
  endfunction

  // One clock: the model takes the values the DUT sees, then new inputs go out.
  task automatic tick();
    @(posedge clk);
    modelStep();
    rst      <= nextRst;
    req      <= nextReq;
    flitId   <= nextId;
    length   <= nextLen;
    flitData <= nextData;
    @(negedge clk);
    checkOutputs();
  endtask

  task automatic finishTest(input string name);
    testNum++;
    $display("test %0d %s: %0d errors", testNum, name, errorCount - testStartErrors);
    testStartErrors = errorCount;
  endtask

  // ====================================================================
  // Tests
  // ====================================================================

  task automatic priorityCase(input logic [numPorts-1:0] r, input int winner);
    nextReq = r;
    tick();
    checkValue("grant", 32'(grant), 32'(0)); // Not yet, req is one cycle old.
    nextReq = '0;
    tick();
    checkValue("grant", 32'(grant), 32'(numPorts'(1) << winner));
    tick();
    checkValue("grant", 32'(grant), 32'(0));
  endtask

  task automatic rotationTest();
    int owner;
    int cur;
    int runLen;
    int handovers;
    owner     = -1;
    runLen    = 0;
    handovers = 0;
    for (int i = 0; i < numPorts; i++)
    begin
      nextId[i]  = flitHeader;
      nextLen[i] = lengthWidth'(i % 3 + 1);
    end
    tick();
    nextId  = {numPorts{flitBody}};
    nextReq = '1;
    repeat (50)
    begin
      randomData();
      tick();
      cur = grantIndex(grant);
      if (cur == owner)
        runLen++;
      else
      begin
        if (owner >= 0)
        begin
          checkValue("grant", 32'(grant), 32'(numPorts'(1) << ((owner + 1) % numPorts)));
          checkTrue(runLen == owner % 3 + 2,
                    $sformatf("input %0d held %0d cycles", owner, runLen));
          handovers++;
        end
        owner  = cur;
        runLen = 1;
      end
    end
    checkTrue(handovers >= 10, "too few handovers while all inputs requested");
    nextReq = '0;
    tick();
    tick();
  endtask

  task automatic headerHoldTest(input int port, input int waiter, input int newLen);
    int   held;
    int   cur;
    int   tries;
    logic done;
    held  = 0;
    cur   = -1;
    tries = 0;
    done  = 1'b0;
    nextReq      = '0;
    nextId[port]  = flitHeader;
    nextLen[port] = lengthWidth'(newLen);
    tick();
    nextId[port]   = flitBody;
    nextReq[port]   = 1'b1;
    nextReq[waiter] = 1'b1;
    while (!done && tries < 24)
    begin
      randomData();
      tick();
      tries++;
      cur = grantIndex(grant);
      if (cur == port)
        held++;
      else if (held > 0)
        done = 1'b1;
    end
    checkTrue(done, "grant to the header-loaded input never ended");
    checkTrue(held == newLen + 1, $sformatf("input %0d held %0d cycles", port, held));
    checkValue("grant", 32'(grant), 32'(numPorts'(1) << waiter));
    nextReq = '0;
    tick();
    tick();
  endtask

  initial
  begin
    int validSeen;
    clk             = 1'b0;
    rst            <= 1'b1;
    req            <= '0;
    flitId         <= '0;
    length         <= '0;
    flitData       <= '0;
    lfsr            = 16'd34003;
    passCount       = 0;
    errorCount      = 0;
    testNum         = 0;
    testStartErrors = 0;
    modelOwner      = -1;
    validSeen       = 0;
    nextRst  = 1'b1;
    nextReq  = '1; // Requests during reset must be ignored.
    nextId   = {numPorts{flitBody}};
    nextLen  = '0;
    nextData = '0;

    repeat (7)
    begin
      tick();
      checkValue("grant", 32'(grant), 32'(0));
      checkValue("outValid", 32'(outValid), 32'(0));
    end
    nextRst = 1'b0;
    nextReq = '0;
    tick();
    tick();
    checkValue("grant", 32'(grant), 32'(0));
    checkValue("outValid", 32'(outValid), 32'(0));
    finishTest("reset");

    priorityCase(5'b11111, portLocal);
    priorityCase(5'b11010, portNorth);
    priorityCase(5'b11000, portWest);
    priorityCase(5'b10000, portSouth);
    finishTest("priority from idle");

    rotationTest();
    finishTest("round-robin rotation");

    headerHoldTest(portEast, portWest, 6);
    headerHoldTest(portNorth, portSouth, 0);
    headerHoldTest(portLocal, portEast, 4);
    finishTest("header-loaded limit");

    repeat (40)
    begin
      randomInputs();
      tick();
      if (outValid)
        validSeen++;
    end
    checkTrue(validSeen > 0, "outValid never rose during data traffic");
    finishTest("data path");

    repeat (300)
    begin
      randomInputs();
      tick();
    end
    nextReq = '0;
    tick();
    tick();
    checkValue("grant", 32'(grant), 32'(0));
    checkValue("outValid", 32'(outValid), 32'(0));
    finishTest("random traffic");

    $display("checks passed: %0d, errors: %0d", passCount, errorCount);
    if (errorCount == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

endmodule

`default_nettype wire

/* sources.f */
verilog/nocPkg.sv
verilog/grantFsm.sv
verilog/grantTimer.sv
verilog/flitMux.sv
verilog/routerOutputPort.sv
sim/routerOutputPortTb.sv

/* run.sh */
#!/bin/sh
# Builds the router output port testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD=obj_dir
TOP=routerOutputPortTb

verilator --binary --timing --assert \
  -f sources.f \
  --top-module "$TOP" \
  --Mdir "$BUILD" \
  -o "$TOP"
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD/$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q ">>> FAIL" "$LOG"; then
  echo "Simulation reported failure"
  exit 1
fi

if ! grep -q ">>> PASS" "$LOG"; then
  echo "Simulation ended without a result"
  exit 1
fi

echo "Simulation passed"
exit 0
